// ==== src/dmem_macros.svh ====
// Operation codes are 3 bits wide; the array depth must equal 2**DMEM_IDX_W for addresses to wrap.
`ifndef DMEM_MACROS_SVH
`define DMEM_MACROS_SVH

// Byte access, sign-extended and zero-extended on a load.
`define DMEM_OP_LB   3'd0
`define DMEM_OP_LBU  3'd1

// Halfword access.
`define DMEM_OP_LH   3'd2
`define DMEM_OP_LHU  3'd3

// Word access.
`define DMEM_OP_LW   3'd4
`define DMEM_OP_LWU  3'd5

// Doubleword access, no extension needed.
`define DMEM_OP_LD   3'd6

// No memory operation this cycle.
`define DMEM_OP_NONE 3'd7

// Number of doublewords held on chip.
`define DMEM_DEPTH   512

// Bits of byte address above the lane offset that select a doubleword.
`define DMEM_IDX_W   9

`endif

// ==== src/dmem_pkg.sv ====
// Widths are fixed at 64 bits of data and address; the index width follows DMEM_IDX_W.
`include "dmem_macros.svh"

package dmem_pkg;

  // One doubleword of data as it sits in the array.
  typedef logic [63:0] dword_t;

  // Full byte address as seen on the port.
  typedef logic [63:0] addr_t;

  // Width and signedness selector.
  typedef logic [2:0] mem_op_t;

  // One write strobe per byte lane, lane 0 in bit 0.
  typedef logic [7:0] byte_mask_t;

  // Byte position inside a doubleword.
  typedef logic [2:0] lane_off_t;

  // Doubleword index into the array.
  typedef logic [`DMEM_IDX_W-1:0] mem_idx_t;

endpackage

// ==== src/dmem_store_align.sv ====
// Lanes shifted past lane 7 are dropped, so a misaligned store never spills into the next doubleword.
`timescale 1ns/10ps
`include "dmem_macros.svh"

module dmem_store_align (
  input  logic                i_wr_en,
  input  dmem_pkg::mem_op_t   i_op,
  input  dmem_pkg::lane_off_t i_off,
  input  dmem_pkg::dword_t    i_data,
  output dmem_pkg::byte_mask_t o_wmask,
  output dmem_pkg::dword_t    o_wdata
);

  dmem_pkg::byte_mask_t base_mask;
  dmem_pkg::byte_mask_t shifted_mask;
  dmem_pkg::dword_t     shifted_data;
  logic [5:0]           bit_shift;
  logic                 wr_ok;

  assign wr_ok     = i_wr_en && (i_op != `DMEM_OP_NONE);
  assign bit_shift = {i_off, 3'b000};  // Eight bits per byte lane.

  // Signedness plays no part in a store, only the width.
  always_comb begin
    case (i_op)
      `DMEM_OP_LB,
      `DMEM_OP_LBU: begin
        base_mask = 8'b0000_0001;
      end
      `DMEM_OP_LH,
      `DMEM_OP_LHU: begin
        base_mask = 8'b0000_0011;
      end
      `DMEM_OP_LW,
      `DMEM_OP_LWU: begin
        base_mask = 8'b0000_1111;
      end
      `DMEM_OP_LD: begin
        base_mask = 8'b1111_1111;
      end
      default: begin
        base_mask = 8'b0000_0000;
      end
    endcase
  end

  assign shifted_mask = base_mask << i_off;      // Upper lanes fall off the top.
  assign shifted_data = i_data << bit_shift;     // Data follows the mask to its lanes.

  always_comb begin
    if (wr_ok) begin
      o_wmask = shifted_mask;
    end else begin
      o_wmask = '0;
    end
  end

  // Unmasked lanes are never written, so the data needs no gating.
  assign o_wdata = shifted_data;

endmodule

// ==== src/dmem_load_align.sv ====
// Result appears one cycle after the request; bytes past lane 7 read as zero before extension.
`timescale 1ns/10ps
`include "dmem_macros.svh"

module dmem_load_align (
  input  logic                i_clk,
  input  logic                i_rst,
  input  logic                i_rd_en,
  input  dmem_pkg::mem_op_t   i_op,
  input  dmem_pkg::lane_off_t i_off,
  input  dmem_pkg::dword_t    i_rdata,
  output dmem_pkg::dword_t    o_data
);

  dmem_pkg::dword_t shifted;
  dmem_pkg::dword_t load_val;
  logic [5:0]       bit_shift;
  logic             rd_ok;

  assign rd_ok     = i_rd_en && (i_op != `DMEM_OP_NONE);
  assign bit_shift = {i_off, 3'b000};
  assign shifted   = i_rdata >> bit_shift;  // Zeros fill from the top.

  always_comb begin
    case (i_op)
      `DMEM_OP_LB: begin
        load_val = {{56{shifted[7]}}, shifted[7:0]};
      end
      `DMEM_OP_LBU: begin
        load_val = {56'd0, shifted[7:0]};
      end
      `DMEM_OP_LH: begin
        load_val = {{48{shifted[15]}}, shifted[15:0]};
      end
      `DMEM_OP_LHU: begin
        load_val = {48'd0, shifted[15:0]};
      end
      `DMEM_OP_LW: begin
        load_val = {{32{shifted[31]}}, shifted[31:0]};
      end
      `DMEM_OP_LWU: begin
        load_val = {32'd0, shifted[31:0]};
      end
      `DMEM_OP_LD: begin
        load_val = shifted;
      end
      default: begin
        load_val = '0;
      end
    endcase
    if (!rd_ok) begin
      load_val = '0;  // Idle cycles return zero.
    end
  end

  // Holding reset through the last reset edge leaves zero on o_data for the following cycle.
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_data <= '0;
    end else begin
      o_data <= load_val;
    end
  end

endmodule

// ==== src/dmem_array.sv ====
// Contents are undefined after power-up and are not touched by reset.
`timescale 1ns/10ps
`include "dmem_macros.svh"

module dmem_array (
  input  logic                 i_clk,
  input  dmem_pkg::byte_mask_t i_wmask,
  input  dmem_pkg::dword_t     i_wdata,
  input  dmem_pkg::mem_idx_t   i_widx,
  input  dmem_pkg::mem_idx_t   i_ridx,
  output dmem_pkg::dword_t     o_rdata
);

  dmem_pkg::dword_t mem [`DMEM_DEPTH];

  // Only lanes with a set strobe change; an all-zero mask leaves the word as it was.
  always_ff @(posedge i_clk) begin
    for (int lane = 0; lane < 8; lane++) begin
      if (i_wmask[lane]) begin
        mem[i_widx][lane*8 +: 8] <= i_wdata[lane*8 +: 8];
      end
    end
  end

  // A read in the same cycle as a write to the same word sees the old contents.
  assign o_rdata = mem[i_ridx];

endmodule

// ==== src/dmem_top.sv ====
// Address bits above the index are ignored, so accesses wrap every DMEM_DEPTH doublewords.
`timescale 1ns/10ps
`include "dmem_macros.svh"

module dmem_top (
  input  logic              i_clk,
  input  logic              i_rst,
  input  dmem_pkg::addr_t   i_addr,
  input  dmem_pkg::dword_t  i_data,
  input  dmem_pkg::mem_op_t i_op,
  input  logic              i_wr_en,
  input  logic              i_rd_en,
  output dmem_pkg::dword_t  o_data
);

  dmem_pkg::lane_off_t  lane_off;
  dmem_pkg::mem_idx_t   mem_idx;
  dmem_pkg::byte_mask_t store_mask;
  dmem_pkg::dword_t     store_data;
  dmem_pkg::dword_t     rd_dword;

  assign lane_off = i_addr[2:0];                 // Byte within the doubleword.
  assign mem_idx  = i_addr[3 +: `DMEM_IDX_W];    // Doubleword select.

  dmem_store_align u_store (
    .i_wr_en (i_wr_en),
    .i_op    (i_op),
    .i_off   (lane_off),
    .i_data  (i_data),
    .o_wmask (store_mask),
    .o_wdata (store_data)
  );

  // Loads and stores share one address, so both ports use the same index.
  dmem_array u_array (
    .i_clk   (i_clk),
    .i_wmask (store_mask),
    .i_wdata (store_data),
    .i_widx  (mem_idx),
    .i_ridx  (mem_idx),
    .o_rdata (rd_dword)
  );

  dmem_load_align u_load (
    .i_clk   (i_clk),
    .i_rst   (i_rst),
    .i_rd_en (i_rd_en),
    .i_op    (i_op),
    .i_off   (lane_off),
    .i_rdata (rd_dword),
    .o_data  (o_data)
  );

endmodule

// ==== verif/dmem_sva.sv ====
// Bound into dmem_top and watches its internal store mask and lane offset; the checks also hold during reset.
`timescale 1ns/10ps
`include "dmem_macros.svh"

module dmem_sva (
  input logic                 i_clk,
  input logic                 i_rst,
  input logic                 i_wr_en,
  input dmem_pkg::mem_op_t    i_op,
  input dmem_pkg::lane_off_t  i_off,
  input dmem_pkg::byte_mask_t i_wmask,
  input dmem_pkg::dword_t     i_load_data
);

  dmem_pkg::byte_mask_t mask_down;
  logic [8:0]           mask_inc;
  logic                 store_off;

  assign store_off = !i_wr_en || (i_op == `DMEM_OP_NONE);
  assign mask_down = i_wmask >> i_off;  // Set lanes moved down to lane 0.
  assign mask_inc  = {1'b0, mask_down} + 9'd1;

  idle_mask_zero: assert property (@(posedge i_clk) store_off |-> (i_wmask == '0))
    else $error("store mask %h is not zero while the store is disabled", i_wmask);

  // A run of ones plus one has no bit in common with the run.
  mask_contiguous: assert property (
    @(posedge i_clk) (i_wmask != '0) |->
      (mask_down[0] && (({1'b0, mask_down} & mask_inc) == 9'd0) &&
       ((mask_down << i_off) == i_wmask)))
    else $error("store mask %h is not one run starting at lane %0d", i_wmask, i_off);

  reset_clears_data: assert property (@(posedge i_clk) i_rst |=> (i_load_data == '0))
    else $error("load data %h is not zero after a reset cycle", i_load_data);

endmodule

bind dmem_top dmem_sva u_sva (
  .i_clk       (i_clk),
  .i_rst       (i_rst),
  .i_wr_en     (i_wr_en),
  .i_op        (i_op),
  .i_off       (lane_off),
  .i_wmask     (store_mask),
  .i_load_data (o_data)
);

// ==== verif/dmem_tb.sv ====
// Expected values come from a byte-level reference memory; every load targets a word the test wrote first.
`timescale 1ns/10ps
`include "dmem_macros.svh"

module dmem_tb;

  localparam int DRAIN_LIMIT   = 50;
  localparam int RANDOM_CYCLES = 2000;

  logic              i_clk;
  logic              i_rst;
  dmem_pkg::addr_t   i_addr;
  dmem_pkg::dword_t  i_data;
  dmem_pkg::mem_op_t i_op;
  logic              i_wr_en;
  logic              i_rd_en;
  dmem_pkg::dword_t  o_data;

  dmem_pkg::dword_t ref_mem [`DMEM_DEPTH];
  dmem_pkg::dword_t exp_q [$];
  int               due_q [$];
  int               cyc = 0;
  int               check_count = 0;
  int               err_count = 0;
  int               test_checks = 0;
  int               test_errs = 0;

  dmem_top UUT (
    .i_clk   (i_clk),
    .i_rst   (i_rst),
    .i_addr  (i_addr),
    .i_data  (i_data),
    .i_op    (i_op),
    .i_wr_en (i_wr_en),
    .i_rd_en (i_rd_en),
    .o_data  (o_data)
  );

  initial begin
    i_clk = 1'b0;
    forever #10 i_clk = ~i_clk;
  end

  // Only changes on the rising edge, so it is steady when checks run.
  always @(posedge i_clk) begin
    cyc <= cyc + 1;
  end

  function automatic int access_bytes(input dmem_pkg::mem_op_t op);
    case (op)
      `DMEM_OP_LB, `DMEM_OP_LBU: return 1;
      `DMEM_OP_LH, `DMEM_OP_LHU: return 2;
      `DMEM_OP_LW, `DMEM_OP_LWU: return 4;
      `DMEM_OP_LD: return 8;
      default: return 0;
    endcase
  endfunction

  function automatic dmem_pkg::dword_t fill_pattern(input int idx);
    return {32'h1357_9bdf ^ (idx * 32'h0101_0101), 32'h2468_ace0 + idx};
  endfunction

  function automatic void ref_store(input dmem_pkg::addr_t addr, input dmem_pkg::mem_op_t op,
                                    input dmem_pkg::dword_t data, input logic wr_en);
    int idx;
    int off;
    int nbytes;
    idx    = int'((addr >> 3) % `DMEM_DEPTH);
    off    = int'(addr % 8);
    nbytes = wr_en ? access_bytes(op) : 0;
    for (int b = 0; b < nbytes; b++) begin
      if (off + b < 8) begin
        ref_mem[idx][(off + b) * 8 +: 8] = data[b * 8 +: 8];  // Bytes past lane 7 are lost.
      end
    end
  endfunction

  function automatic dmem_pkg::dword_t ref_load(input dmem_pkg::addr_t addr,
                                                input dmem_pkg::mem_op_t op, input logic rd_en);
    dmem_pkg::dword_t val;
    int               idx;
    int               off;
    int               nbytes;
    logic             is_signed;
    idx       = int'((addr >> 3) % `DMEM_DEPTH);
    off       = int'(addr % 8);
    nbytes    = rd_en ? access_bytes(op) : 0;
    is_signed = (op == `DMEM_OP_LB) || (op == `DMEM_OP_LH) || (op == `DMEM_OP_LW);
    val       = '0;
    for (int b = 0; b < nbytes; b++) begin
      if (off + b < 8) begin
        val[b * 8 +: 8] = ref_mem[idx][(off + b) * 8 +: 8];
      end
    end
    if (is_signed && nbytes > 0 && val[nbytes * 8 - 1]) begin
      for (int b = nbytes; b < 8; b++) begin
        val[b * 8 +: 8] = 8'hff;
      end
    end
    return val;
  endfunction

  task automatic compare_data(input dmem_pkg::dword_t exp, input dmem_pkg::dword_t act);
    check_count++;
    assert (act === exp) else begin
      err_count++;
      $display("CHECK FAILED o_data expected=%h actual=%h", exp, act);
    end
  endtask

  task automatic drive_cycle(input dmem_pkg::addr_t addr, input dmem_pkg::dword_t data,
                             input dmem_pkg::mem_op_t op, input logic wr, input logic rd);
    dmem_pkg::dword_t exp;
    @(negedge i_clk);
    i_addr  = addr;
    i_data  = data;
    i_op    = op;
    i_wr_en = wr;
    i_rd_en = rd;
    exp = ref_load(addr, op, rd);  // The load sees the word as it was before this store.
    ref_store(addr, op, data, wr);
    exp_q.push_back(exp);
    due_q.push_back(cyc + 1);
  endtask

  task automatic store_dword(input dmem_pkg::addr_t addr, input dmem_pkg::dword_t data);
    drive_cycle(addr, data, `DMEM_OP_LD, 1'b1, 1'b0);
  endtask

  task automatic load_data(input dmem_pkg::addr_t addr, input dmem_pkg::mem_op_t op);
    drive_cycle(addr, '0, op, 1'b0, 1'b1);
  endtask

  task automatic wait_checks_done(input string name);
    int waited;
    waited = 0;
    drive_cycle('0, '0, `DMEM_OP_NONE, 1'b0, 1'b0);  // Park the inputs so no access repeats.
    while (exp_q.size() > 0 && waited < DRAIN_LIMIT) begin
      @(negedge i_clk);
      waited++;
    end
    if (exp_q.size() > 0) begin
      $display("Timeout in test %s: %0d load results never arrived", name, exp_q.size());
      $display("Done: errors found");
      $finish;
    end
  endtask

  task automatic begin_test();
    test_checks = check_count;
    test_errs   = err_count;
  endtask

  task automatic end_test(input string name);
    wait_checks_done(name);
    $display("Test %s: %0d checks, %0d errors", name, check_count - test_checks,
             err_count - test_errs);
  endtask

  // Each result is compared in the cycle it was due, one edge after its request.
  initial begin
    forever begin
      @(negedge i_clk);
      while (due_q.size() > 0 && due_q[0] == cyc) begin
        compare_data(exp_q.pop_front(), o_data);
        void'(due_q.pop_front());
      end
    end
  end

  initial begin
    dmem_pkg::addr_t   addr;
    dmem_pkg::dword_t  data;
    dmem_pkg::dword_t  pat;
    dmem_pkg::dword_t  pats [2];
    dmem_pkg::mem_op_t op;
    int                idx;
    int                dw_idx [5];

    void'($urandom(32'hbf43_e302));
    i_rst   = 1'b1;
    i_addr  = '0;
    i_data  = '0;
    i_op    = `DMEM_OP_NONE;
    i_wr_en = 1'b0;
    i_rd_en = 1'b0;

    begin_test();
    pat = fill_pattern(40);
    ref_store(64'd320, `DMEM_OP_LD, pat, 1'b1);
    for (int c = 0; c < 16; c++) begin
      @(negedge i_clk);
      compare_data('0, o_data);
      i_addr  = 64'd320;
      i_data  = pat;
      i_op    = `DMEM_OP_LD;
      i_wr_en = (c == 0);  // The store still lands while reset is high.
      i_rd_en = (c != 0);  // Live loads that reset has to hide.
    end
    i_rst = 1'b0;
    @(negedge i_clk);
    compare_data(ref_load(64'd320, `DMEM_OP_LD, 1'b1), o_data);  // First load out of reset.
    end_test("reset");

    begin_test();
    dw_idx = '{0, 1, 7, 255, `DMEM_DEPTH - 1};
    foreach (dw_idx[i]) begin
      store_dword(64'(dw_idx[i] * 8), fill_pattern(dw_idx[i]));
    end
    store_dword(64'hdead_0000_0000_0018, 64'hfeed_face_0bad_f00d);  // Upper bits drop, index 3.
    foreach (dw_idx[i]) begin
      load_data(64'(dw_idx[i] * 8), `DMEM_OP_LD);
    end
    load_data(64'h0000_0000_0000_0018, `DMEM_OP_LD);
    load_data(64'h0000_0000_0000_1038, `DMEM_OP_LD);  // Wraps onto index 7.
    end_test("doubleword access");

    begin_test();
    for (int w = 0; w < 3; w++) begin
      for (int off = 0; off < 8; off++) begin
        idx  = 64 + w * 8 + off;
        addr = 64'(idx * 8);
        op   = (w == 0) ? `DMEM_OP_LB : ((w == 1) ? `DMEM_OP_LH : `DMEM_OP_LW);
        store_dword(addr, fill_pattern(idx));
        drive_cycle(addr + 64'(off), {$urandom(), $urandom()}, op, 1'b1, 1'b0);
        load_data(addr, `DMEM_OP_LD);
      end
    end
    end_test("narrow stores");

    begin_test();
    pats[0] = 64'hf0e1_d2c3_b4a5_9687;  // Every byte has its top bit set.
    pats[1] = 64'h7061_5243_3425_1607;
    for (int p = 0; p < 2; p++) begin
      store_dword(64'd800, pats[p]);
      for (int off = 0; off < 8; off++) begin
        for (int o = 0; o < 8; o++) begin
          load_data(64'(800 + off), dmem_pkg::mem_op_t'(o));
        end
      end
    end
    end_test("signed and unsigned loads");

    begin_test();
    pat = fill_pattern(120);
    store_dword(64'd960, pat);
    drive_cycle(64'd960, ~pat, `DMEM_OP_LD, 1'b0, 1'b0);
    drive_cycle(64'd963, ~pat, `DMEM_OP_NONE, 1'b1, 1'b0);
    load_data(64'd960, `DMEM_OP_LD);
    drive_cycle(64'd960, '0, `DMEM_OP_LD, 1'b0, 1'b0);
    drive_cycle(64'd962, '0, `DMEM_OP_NONE, 1'b0, 1'b1);
    drive_cycle(64'd961, ~pat, `DMEM_OP_NONE, 1'b1, 1'b1);
    load_data(64'd960, `DMEM_OP_LD);
    end_test("disabled and none operations");

    begin_test();
    for (int i = 0; i < 8; i++) begin
      store_dword(64'(i * 8), {$urandom(), $urandom()});
    end
    for (int i = 0; i < RANDOM_CYCLES; i++) begin
      addr = {$urandom(), $urandom()};
      addr[3 +: `DMEM_IDX_W] = `DMEM_IDX_W'($urandom_range(7, 0));  // Few words, many hits.
      data = {$urandom(), $urandom()};
      op   = dmem_pkg::mem_op_t'($urandom_range(7, 0));
      drive_cycle(addr, data, op, 1'($urandom_range(1, 0)), 1'($urandom_range(1, 0)));
    end
    end_test("random mix");

    $display("Summary: %0d checks, %0d errors", check_count, err_count);
    if (err_count == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// ==== all.f ====
+incdir+src
src/dmem_pkg.sv
src/dmem_store_align.sv
src/dmem_load_align.sv
src/dmem_array.sv
src/dmem_top.sv
verif/dmem_sva.sv
verif/dmem_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it, and passes only if the pass line is printed.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/10ps \
  -f all.f --top-module dmem_tb -o dmem_sim \
  && ./obj_dir/dmem_sim | tee /dev/stderr | grep -qxF "Done: no errors" \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }
